// ==== vlog.f ====
verilog/fp_ex_pkg.sv
verilog/fp_ex_decode.sv
verilog/fp_noncomp.sv
verilog/fp_i2f_conv.sv
verilog/fp_ex.sv
testbench/tb_clock_gen.sv
testbench/fp_ex_assertions.sv
testbench/fp_ex_tb.sv

// ==== Bender.yml ====
package:
  name: fp_ex

sources:
  - verilog/fp_ex_pkg.sv
  - verilog/fp_ex_decode.sv
  - verilog/fp_noncomp.sv
  - verilog/fp_i2f_conv.sv
  - verilog/fp_ex.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/fp_ex_assertions.sv
      - testbench/fp_ex_tb.sv

// ==== testbench/fp_ex_tb.sv ====
`timescale 1ns/1ps

module fp_ex_tb;

  logic        clk;
  logic        arst_n;
  logic        op_valid;
  logic [31:0] instr;
  logic [2:0]  frm_csr;
  logic [31:0] frs1;
  logic [31:0] frs2;
  logic [31:0] rs1;
  logic        result_valid;
  logic [31:0] result;
  logic [4:0]  fflags;
  logic        busy;
  int          err_cnt;
  int          cycle_cnt;

  tb_clock_gen u_clock_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  fp_ex UUT (
    .clk            (clk),
    .arst_n_i       (arst_n),
    .op_valid_i     (op_valid),
    .instr_i        (instr),
    .frm_csr_i      (frm_csr),
    .frs1_i         (frs1),
    .frs2_i         (frs2),
    .rs1_i          (rs1),
    .result_valid_o (result_valid),
    .result_o       (result),
    .fflags_o       (fflags),
    .busy_o         (busy)
  );

  bind fp_ex fp_ex_assertions u_assertions (
    .clk_i          (clk),
    .arst_n_i       (arst_n_i),
    .result_valid_i (result_valid_o),
    .result_i       (result_o),
    .fflags_i       (fflags_o),
    .busy_i         (busy_o)
  );

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      err_cnt++;
      abort_run();
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Error: %s", what);
      err_cnt++;
      abort_run();
    end
  endtask

  // Budget covers 40 conversions at 34 cycles plus the single-cycle ops
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == 3000) begin
      $display("Error: timeout after %0d cycles", cycle_cnt);
      abort_run();
    end
  end

  // R-type OP-FP word with arbitrary register fields
  function automatic logic [31:0] make_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                            input logic [2:0] funct3);
    return {funct7, rs2, 5'd3, funct3, 5'd4, fp_ex_pkg::OP_FP};
  endfunction

  function automatic logic nan_of(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic snan_of(input logic [31:0] x);
    return nan_of(x) && (x[22] == 1'b0);
  endfunction

  // Unsigned key that sorts like the float with -0 below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : (x | 32'h80000000);
  endfunction

  // Returns {NX, result} from exact division of the magnitude into kept and dropped bits
  function automatic logic [32:0] i2f_model(input logic [31:0] x, input logic is_uns,
                                            input logic [2:0] rm);
    logic        sign;
    logic [31:0] mag;
    logic [31:0] kept;
    logic [31:0] rem;
    logic [31:0] half;
    logic        up;
    logic [7:0]  e;
    int          msb;
    int          drop;
    sign = !is_uns && x[31];
    mag  = sign ? (32'd0 - x) : x;
    if (mag == 32'd0) begin
      return 33'd0;
    end
    msb = 0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) begin
        msb = i;
      end
    end
    e = 8'(127 + msb);
    if (msb <= 23) begin
      // Fits in 24 bits so it is exact
      kept = mag << (23 - msb);
      rem  = 32'd0;
      half = 32'd1;
    end else begin
      drop = msb - 23;
      kept = mag >> drop;
      rem  = mag & ((32'd1 << drop) - 32'd1);
      half = 32'd1 << (drop - 1);
    end
    case (rm)
      3'd0: up = (rem > half) || ((rem == half) && kept[0]);
      3'd1: up = 1'b0;
      3'd2: up = sign && (rem != 32'd0);
      3'd3: up = !sign && (rem != 32'd0);
      default: up = (rem >= half);
    endcase
    kept = kept + {31'd0, up};
    // Rounding carried into bit 24
    if (kept[24]) begin
      kept = kept >> 1;
      e    = e + 8'd1;
    end
    return {rem != 32'd0, sign, e, kept[22:0]};
  endfunction

  // One single-cycle op checked in its own cycle
  task automatic issue_single(input logic [31:0] word, input logic [31:0] a,
                              input logic [31:0] b, input logic [31:0] x,
                              input logic [31:0] exp_val, input logic [4:0] exp_flags);
    @(posedge clk);
    op_valid <= 1'b1;
    instr    <= word;
    frs1     <= a;
    frs2     <= b;
    rs1      <= x;
    @(negedge clk);
    compare_value("result_valid_o", {31'd0, result_valid}, 32'd1);
    compare_value("result_o", result, exp_val);
    compare_value("fflags_o", {27'd0, fflags}, {27'd0, exp_flags});
    compare_value("busy_o", {31'd0, busy}, 32'd0);
    @(posedge clk);
    op_valid <= 1'b0;
  endtask

  task automatic issue_convert(input logic [31:0] x, input logic is_uns,
                               input logic [2:0] rm, input logic use_dyn);
    logic [32:0] exp;
    logic        got_result;
    int          waited;
    exp        = i2f_model(x, is_uns, rm);
    got_result = 1'b0;
    waited     = 0;
    @(posedge clk);
    op_valid <= 1'b1;
    instr    <= make_word(fp_ex_pkg::FP7_FCVTSW, {4'd0, is_uns},
                          use_dyn ? fp_ex_pkg::FRM_DYN : rm);
    // Static modes see a reserved frm that must be ignored
    frm_csr  <= use_dyn ? rm : 3'd6;
    rs1      <= x;
    @(posedge clk);
    op_valid <= 1'b0;
    while (!got_result) begin
      @(negedge clk);
      if (result_valid) begin
        got_result = 1'b1;
      end else begin
        expect_true(busy, "busy_o low before the conversion result");
        waited++;
        expect_true(waited < 40, "no conversion result within 40 cycles");
      end
    end
    compare_value("result_o", result, exp[31:0]);
    compare_value("fflags_o", {27'd0, fflags}, {31'd0, exp[32]});
    compare_value("busy_o", {31'd0, busy}, 32'd0);
    @(posedge clk);
  endtask

  // Optional single request and then 40 cycles without strobe or busy
  task automatic expect_silence(input logic drive, input logic [31:0] word,
                                input logic [2:0] frm);
    if (drive) begin
      @(posedge clk);
      op_valid <= 1'b1;
      instr    <= word;
      frm_csr  <= frm;
      rs1      <= $urandom;
    end
    repeat (40) begin
      @(negedge clk);
      expect_true(!result_valid, "unexpected result_valid_o");
      expect_true(!busy, "unexpected busy_o");
      @(posedge clk);
      op_valid <= 1'b0;
    end
  endtask

  task automatic sign_inject_and_moves();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] x;
    repeat (6) begin
      a = $urandom;
      b = $urandom;
      x = $urandom;
      // Magnitude of frs1 with a sign taken from frs2
      issue_single(make_word(fp_ex_pkg::FP7_FSGNJ, 5'd0, 3'd0), a, b, x,
                   (a & 32'h7fffffff) | (b & 32'h80000000), 5'd0);
      issue_single(make_word(fp_ex_pkg::FP7_FSGNJ, 5'd0, 3'd1), a, b, x,
                   (a & 32'h7fffffff) | (~b & 32'h80000000), 5'd0);
      // Sign of frs1 flips when frs2 is negative
      issue_single(make_word(fp_ex_pkg::FP7_FSGNJ, 5'd0, 3'd2), a, b, x,
                   a ^ (b & 32'h80000000), 5'd0);
      issue_single(make_word(fp_ex_pkg::FP7_FMVXW, 5'd0, 3'd0), a, b, x, a, 5'd0);
      issue_single(make_word(fp_ex_pkg::FP7_FMVWX, 5'd0, 3'd0), a, b, x, x, 5'd0);
    end
  endtask

  task automatic min_max_cases();
    logic [31:0] pa [10];
    logic [31:0] pb [10];
    logic [31:0] exp;
    logic        a_first;
    pa = '{32'h00000000, 32'h80000000, 32'h7fc00000, 32'h3f800000, 32'h7fc00000,
           32'h7f800001, 32'h3f800000, $urandom, $urandom, $urandom};
    pb = '{32'h80000000, 32'h00000000, 32'h3f800000, 32'hffc12345, 32'hffc00005,
           32'h40000000, 32'hc0400000, $urandom, $urandom, $urandom};
    for (int i = 0; i < 10; i++) begin
      for (int mx = 0; mx < 2; mx++) begin
        a_first = (order_key(pa[i]) < order_key(pb[i])) ^ (mx == 1);
        if (nan_of(pa[i]) && nan_of(pb[i])) begin
          exp = fp_ex_pkg::CANON_NAN;
        end else if (nan_of(pa[i])) begin
          exp = pb[i];
        end else if (nan_of(pb[i])) begin
          exp = pa[i];
        end else begin
          exp = a_first ? pa[i] : pb[i];
        end
        issue_single(make_word(fp_ex_pkg::FP7_FMINMAX, 5'd0, 3'(mx)), pa[i], pb[i], 32'd0,
                     exp, {snan_of(pa[i]) || snan_of(pb[i]), 4'd0});
      end
    end
  endtask

  task automatic compare_cases();
    logic [31:0] pa [8];
    logic [31:0] pb [8];
    logic        any_nan;
    logic        eq;
    logic        lt;
    pa = '{32'h3f800000, 32'h40000000, 32'h00000000, 32'hbfc00000, 32'h7fc00000,
           32'h7f800001, $urandom, $urandom};
    pb = '{32'h40000000, 32'h3f800000, 32'h80000000, 32'hbfc00000, 32'h3f800000,
           32'h3f800000, $urandom, $urandom};
    for (int i = 0; i < 8; i++) begin
      any_nan = nan_of(pa[i]) || nan_of(pb[i]);
      // Same bits, or both zero whatever the signs
      eq      = (order_key(pa[i]) == order_key(pb[i])) ||
                (((pa[i] | pb[i]) & 32'h7fffffff) == 32'd0);
      lt      = order_key(pa[i]) < order_key(pb[i]);
      // FEQ is quiet
      issue_single(make_word(fp_ex_pkg::FP7_FCMP, 5'd0, 3'd2), pa[i], pb[i], 32'd0,
                   {31'd0, !any_nan && eq}, {snan_of(pa[i]) || snan_of(pb[i]), 4'd0});
      issue_single(make_word(fp_ex_pkg::FP7_FCMP, 5'd0, 3'd1), pa[i], pb[i], 32'd0,
                   {31'd0, !any_nan && lt && !eq}, {any_nan, 4'd0});
      issue_single(make_word(fp_ex_pkg::FP7_FCMP, 5'd0, 3'd0), pa[i], pb[i], 32'd0,
                   {31'd0, !any_nan && (lt || eq)}, {any_nan, 4'd0});
    end
  endtask

  task automatic classify_cases();
    logic [31:0] vals [10];
    // Index is the expected class bit from -inf up to quiet NaN
    vals = '{32'hff800000, 32'hbf800000, 32'h80000001, 32'h80000000, 32'h00000000,
             32'h00000001, 32'h3f800000, 32'h7f800000, 32'h7f800001, 32'h7fc00000};
    for (int i = 0; i < 10; i++) begin
      issue_single(make_word(fp_ex_pkg::FP7_FMVXW, 5'd0, 3'd1), vals[i], 32'd0, 32'd0,
                   32'd1 << i, 5'd0);
    end
  endtask

  task automatic int_to_float_cases();
    // Exact zero, extremes and carry into the exponent
    issue_convert(32'h00000000, 1'b0, 3'd0, 1'b0);
    issue_convert(32'h80000000, 1'b0, 3'd2, 1'b0);
    issue_convert(32'h80000000, 1'b1, 3'd0, 1'b1);
    issue_convert(32'hffffffff, 1'b1, 3'd0, 1'b0);
    issue_convert(32'h7fffffff, 1'b0, 3'd3, 1'b1);
    // Halfway with odd kept bit for both signs in every mode
    for (int m = 0; m < 5; m++) begin
      issue_convert(32'h01000003, 1'b0, 3'(m), 1'b0);
      issue_convert(32'hfefffffd, 1'b0, 3'(m), 1'b1);
    end
    repeat (25) begin
      issue_convert($urandom, 1'($urandom), 3'($urandom_range(4, 0)), 1'($urandom));
    end
  endtask

  task automatic unsupported_cases();
    // FMADD uses an R4 opcode
    expect_silence(1'b1, {5'd1, 2'b00, 5'd2, 5'd3, 3'd0, 5'd4, 7'b1000011}, 3'd0);
    // FADD
    expect_silence(1'b1, make_word(7'b0000000, 5'd0, 3'd0), 3'd0);
    // Reserved static mode and then reserved dynamic mode
    expect_silence(1'b1, make_word(fp_ex_pkg::FP7_FCVTSW, 5'd0, 3'd5), 3'd0);
    expect_silence(1'b1, make_word(fp_ex_pkg::FP7_FCVTSW, 5'd0, fp_ex_pkg::FRM_DYN), 3'd6);
  endtask

  initial begin
    err_cnt   = 0;
    cycle_cnt = 0;
    op_valid  = 1'b0;
    instr     = 32'd0;
    frm_csr   = 3'd0;
    frs1      = 32'd0;
    frs2      = 32'd0;
    rs1       = 32'd0;
    void'($urandom(32'hfd2));
    wait (arst_n == 1'b1);
    // Quiet after reset with no request
    expect_silence(1'b0, 32'd0, 3'd0);
    sign_inject_and_moves();
    min_max_cases();
    compare_cases();
    classify_cases();
    int_to_float_cases();
    unsupported_cases();
    if (err_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

// ==== testbench/fp_ex_assertions.sv ====
`timescale 1ns/1ps

module fp_ex_assertions (
  input logic        clk_i,
  input logic        arst_n_i,
  input logic        result_valid_i,
  input logic [31:0] result_i,
  input logic [4:0]  fflags_i,
  input logic        busy_i
);

  // Converter idle while reset is held
  property busy_low_in_reset;
    @(posedge clk_i) !arst_n_i |-> !busy_i;
  endproperty

  // Strobe after a busy phase lasts one cycle
  property result_pulse_single;
    @(posedge clk_i) disable iff (!arst_n_i)
      ($past(busy_i) && result_valid_i) |=> !result_valid_i;
  endproperty

  // Busy drops exactly with the strobe
  property busy_falls_with_result;
    @(posedge clk_i) disable iff (!arst_n_i)
      $fell(busy_i) |-> result_valid_i;
  endproperty

  property outputs_known;
    @(posedge clk_i) disable iff (!arst_n_i)
      !$isunknown({result_valid_i, busy_i, fflags_i, result_i});
  endproperty

  a_busy_reset: assert property (busy_low_in_reset)
    else $error("busy_o high during reset");
  a_pulse: assert property (result_pulse_single)
    else $error("conversion strobe longer than one cycle");
  a_busy_fall: assert property (busy_falls_with_result)
    else $error("busy_o fell without a result strobe");
  a_known: assert property (outputs_known)
    else $error("X or Z on an output after reset");

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // 8 ns period, first rising edge at 4 ns
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held low for four rising edges
  initial begin
    arst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

// ==== verilog/fp_ex.sv ====
`timescale 1ns/1ps

module fp_ex (
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        op_valid_i,
  input  logic [31:0] instr_i,
  input  logic [2:0]  frm_csr_i,
  input  logic [31:0] frs1_i,
  input  logic [31:0] frs2_i,
  input  logic [31:0] rs1_i,
  output logic        result_valid_o,
  output logic [31:0] result_o,
  output logic [4:0]  fflags_o,
  output logic        busy_o
);

  fp_ex_pkg::rv_instr_u    instr;
  fp_ex_pkg::fp_req_t      req;
  fp_ex_pkg::fp_operands_t opnd;
  fp_ex_pkg::fp_res_t      nc_res;
  fp_ex_pkg::fp_res_t      cv_res;

  assign instr = fp_ex_pkg::rv_instr_u'(instr_i);

  assign opnd.frs1 = frs1_i;
  assign opnd.frs2 = frs2_i;
  assign opnd.rs1  = rs1_i;

  fp_ex_decode u_decode (
    .instr_i   (instr),
    .frm_csr_i (frm_csr_i),
    .req_o     (req)
  );

  // Single-cycle ops, result in the request cycle
  fp_noncomp u_noncomp (
    .op_valid_i (op_valid_i),
    .req_i      (req),
    .opnd_i     (opnd),
    .res_o      (nc_res)
  );

  // Iterative int to float
  fp_i2f_conv u_i2f (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .op_valid_i (op_valid_i),
    .req_i      (req),
    .rs1_i      (rs1_i),
    .busy_o     (busy_o),
    .res_o      (cv_res)
  );

  // At most one unit is valid in a cycle
  always_comb begin
    if (nc_res.valid) begin
      result_valid_o = 1'b1;
      result_o       = nc_res.value;
      fflags_o       = nc_res.fflags;
    end else if (cv_res.valid) begin
      result_valid_o = 1'b1;
      result_o       = cv_res.value;
      fflags_o       = cv_res.fflags;
    end else begin
      result_valid_o = 1'b0;
      result_o       = 32'd0;
      fflags_o       = 5'd0;
    end
  end

endmodule

// ==== verilog/fp_i2f_conv.sv ====
`timescale 1ns/1ps

module fp_i2f_conv (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               op_valid_i,
  input  fp_ex_pkg::fp_req_t req_i,
  input  logic [31:0]        rs1_i,
  output logic               busy_o,
  output fp_ex_pkg::fp_res_t res_o
);

  logic           start;
  logic           done;
  logic           busy_q;
  logic           valid_q;
  logic           sign_q;
  logic [31:0]    mag_q;
  logic [7:0]     exp_q;
  fp_ex_pkg::rm_e rm_q;
  logic [31:0]    value_q;
  logic           nx_q;
  logic           in_sign;
  logic [31:0]    in_mag;
  logic           lsb;
  logic           guard;
  logic           sticky;
  logic           round_up;
  logic [24:0]    rounded;
  logic [7:0]     res_exp;
  logic [22:0]    res_mant;

  // A new request while busy is a caller error and is dropped
  assign start = op_valid_i && (req_i.op == fp_ex_pkg::I2F) && !busy_q;

  // Signed input goes in as its absolute value
  assign in_sign = !req_i.is_unsigned && rs1_i[31];
  assign in_mag  = in_sign ? (~rs1_i + 32'd1) : rs1_i;

  // Normalized, or zero which needs no shifting
  assign done = busy_q && ((mag_q == 32'd0) || mag_q[31]);

  // Bit 31 is the hidden one, bit 8 the last kept
  assign lsb    = mag_q[8];
  assign guard  = mag_q[7];
  assign sticky = |mag_q[6:0];

  always_comb begin
    case (rm_q)
      fp_ex_pkg::RNE: round_up = guard && (sticky || lsb);
      fp_ex_pkg::RTZ: round_up = 1'b0;
      fp_ex_pkg::RDN: round_up = sign_q && (guard || sticky);
      fp_ex_pkg::RUP: round_up = !sign_q && (guard || sticky);
      fp_ex_pkg::RMM: round_up = guard;
      default:        round_up = 1'b0;
    endcase
  end

  // Carry out of the mantissa bumps the exponent
  assign rounded  = {1'b0, mag_q[31:8]} + {24'd0, round_up};
  assign res_exp  = rounded[24] ? (exp_q + 8'd1) : exp_q;
  assign res_mant = rounded[24] ? rounded[23:1] : rounded[22:0];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      // One-cycle result strobe as busy drops
      valid_q <= done;
      if (start) begin
        busy_q <= 1'b1;
      end else if (done) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      sign_q <= in_sign;
      mag_q  <= in_mag;
      exp_q  <= fp_ex_pkg::I2F_EXP_INIT;
      rm_q   <= req_i.rm;
    end else if (done) begin
      if (mag_q == 32'd0) begin
        // Zero converts exactly to +0
        value_q <= 32'd0;
        nx_q    <= 1'b0;
      end else begin
        value_q <= {sign_q, res_exp, res_mant};
        nx_q    <= guard || sticky;
      end
    end else if (busy_q) begin
      // One leading zero per cycle
      mag_q <= {mag_q[30:0], 1'b0};
      exp_q <= exp_q - 8'd1;
    end
  end

  assign busy_o       = busy_q;
  assign res_o.valid  = valid_q;
  assign res_o.value  = value_q;
  // Conversion from 32 bits can only be inexact
  assign res_o.fflags = {4'd0, nx_q};

endmodule

// ==== verilog/fp_noncomp.sv ====
`timescale 1ns/1ps

module fp_noncomp (
  input  logic                    op_valid_i,
  input  fp_ex_pkg::fp_req_t      req_i,
  input  fp_ex_pkg::fp_operands_t opnd_i,
  output fp_ex_pkg::fp_res_t      res_o
);

  logic [31:0] a;
  logic [31:0] b;
  logic        a_nan;
  logic        b_nan;
  logic        a_snan;
  logic        b_snan;
  logic        a_lt_b;
  logic        a_eq_b;
  logic        is_mine;
  logic [9:0]  a_class;

  function automatic logic is_nan(input logic [31:0] x);
    return (&x[30:23]) && (|x[22:0]);
  endfunction

  // Quiet bit clear on a NaN
  function automatic logic is_snan(input logic [31:0] x);
    return is_nan(x) && !x[22];
  endfunction

  // One-hot FCLASS mask, bit 0 is -inf up to bit 9 quiet NaN
  function automatic logic [9:0] fclass(input logic [31:0] x);
    logic       exp_ones;
    logic       exp_zero;
    logic       man_zero;
    logic [9:0] cls;
    exp_ones = &x[30:23];
    exp_zero = ~|x[30:23];
    man_zero = ~|x[22:0];
    cls      = '0;
    if (exp_ones && !man_zero) begin
      cls[x[22] ? 9 : 8] = 1'b1;
    end else if (exp_ones) begin
      cls[x[31] ? 0 : 7] = 1'b1;
    end else if (exp_zero && man_zero) begin
      cls[x[31] ? 3 : 4] = 1'b1;
    end else if (exp_zero) begin
      cls[x[31] ? 2 : 5] = 1'b1;
    end else begin
      cls[x[31] ? 1 : 6] = 1'b1;
    end
    return cls;
  endfunction

  assign a       = opnd_i.frs1;
  assign b       = opnd_i.frs2;
  assign a_nan   = is_nan(a);
  assign b_nan   = is_nan(b);
  assign a_snan  = is_snan(a);
  assign b_snan  = is_snan(b);
  assign a_class = fclass(a);

  // Sign-magnitude order, -0 sits below +0
  always_comb begin
    if (a[31] != b[31]) begin
      a_lt_b = a[31];
    end else if (a[31]) begin
      a_lt_b = (a[30:0] > b[30:0]);
    end else begin
      a_lt_b = (a[30:0] < b[30:0]);
    end
  end

  // Numeric equality treats the two zeros as equal
  assign a_eq_b = (a == b) || ((a[30:0] == 31'd0) && (b[30:0] == 31'd0));

  assign is_mine = (req_i.op == fp_ex_pkg::SGNJ) || (req_i.op == fp_ex_pkg::MINMAX) ||
                   (req_i.op == fp_ex_pkg::CMP) || (req_i.op == fp_ex_pkg::CLASS) ||
                   (req_i.op == fp_ex_pkg::MV_XW) || (req_i.op == fp_ex_pkg::MV_WX);

  always_comb begin
    res_o.valid  = op_valid_i && is_mine;
    res_o.value  = '0;
    res_o.fflags = '0;
    case (req_i.op)
      fp_ex_pkg::SGNJ: begin
        // Magnitude of a, sign built from b
        if (req_i.sub == fp_ex_pkg::FP3_FSGNJ) begin
          res_o.value = {b[31], a[30:0]};
        end else if (req_i.sub == fp_ex_pkg::FP3_FSGNJN) begin
          res_o.value = {~b[31], a[30:0]};
        end else begin
          res_o.value = {a[31] ^ b[31], a[30:0]};
        end
      end
      fp_ex_pkg::MINMAX: begin
        res_o.fflags[4] = a_snan || b_snan;
        if (a_nan && b_nan) begin
          res_o.value = fp_ex_pkg::CANON_NAN;
        end else if (a_nan) begin
          res_o.value = b;
        end else if (b_nan) begin
          res_o.value = a;
        end else if (req_i.sub == fp_ex_pkg::FP3_FMAX) begin
          res_o.value = a_lt_b ? b : a;
        end else begin
          res_o.value = a_lt_b ? a : b;
        end
      end
      fp_ex_pkg::CMP: begin
        if (req_i.sub == fp_ex_pkg::FP3_FEQ) begin
          // Quiet compare, only sNaN is invalid
          res_o.fflags[4] = a_snan || b_snan;
          res_o.value[0]  = !a_nan && !b_nan && a_eq_b;
        end else begin
          // Signaling compares trap on any NaN
          res_o.fflags[4] = a_nan || b_nan;
          if (!a_nan && !b_nan) begin
            if (req_i.sub == fp_ex_pkg::FP3_FLT) begin
              res_o.value[0] = a_lt_b && !a_eq_b;
            end else begin
              res_o.value[0] = a_lt_b || a_eq_b;
            end
          end
        end
      end
      fp_ex_pkg::CLASS: res_o.value = {22'd0, a_class};
      // Raw bit copies either way
      fp_ex_pkg::MV_XW: res_o.value = a;
      fp_ex_pkg::MV_WX: res_o.value = opnd_i.rs1;
      default: res_o.value = '0;
    endcase
  end

endmodule

// ==== verilog/fp_ex_decode.sv ====
`timescale 1ns/1ps

module fp_ex_decode (
  input  fp_ex_pkg::rv_instr_u instr_i,
  input  logic [2:0]           frm_csr_i,
  output fp_ex_pkg::fp_req_t   req_o
);

  logic [2:0] funct3;
  logic [2:0] rm_raw;
  logic       rm_ok;
  logic       is_r4;
  logic       is_op_fp;

  // R-type view for the OP-FP fields
  assign funct3   = instr_i.r.funct3;
  assign is_op_fp = (instr_i.r.opcode == fp_ex_pkg::OP_FP);

  // R4 view picks out the fused multiply-add group, 100xx11
  assign is_r4 = (instr_i.r4.opcode[6:4] == 3'b100) && (instr_i.r4.opcode[1:0] == 2'b11);

  // Static mode from funct3, or fcsr.frm when dynamic
  assign rm_raw = (funct3 == fp_ex_pkg::FRM_DYN) ? frm_csr_i : funct3;
  // Modes 5 to 7 are reserved
  assign rm_ok  = (rm_raw <= 3'd4);

  always_comb begin
    req_o.op          = fp_ex_pkg::NONE;
    req_o.sub         = funct3;
    req_o.is_unsigned = 1'b0;
    req_o.rm          = rm_ok ? fp_ex_pkg::rm_e'(rm_raw) : fp_ex_pkg::RNE;

    // Fused ops have no unit here and stay NONE
    if (!is_r4 && is_op_fp && rm_ok) begin
      case (instr_i.r.funct7)
        fp_ex_pkg::FP7_FSGNJ: begin
          // FSGNJ, FSGNJN, FSGNJX
          if (funct3 <= 3'd2) begin
            req_o.op = fp_ex_pkg::SGNJ;
          end
        end
        fp_ex_pkg::FP7_FMINMAX: begin
          if (funct3 <= fp_ex_pkg::FP3_FMAX) begin
            req_o.op = fp_ex_pkg::MINMAX;
          end
        end
        fp_ex_pkg::FP7_FCMP: begin
          // FLE, FLT, FEQ
          if (funct3 <= fp_ex_pkg::FP3_FEQ) begin
            req_o.op = fp_ex_pkg::CMP;
          end
        end
        fp_ex_pkg::FP7_FMVXW: begin
          // Shared funct7, split by funct3
          if (funct3 == fp_ex_pkg::FP3_FMV) begin
            req_o.op = fp_ex_pkg::MV_XW;
          end else if (funct3 == fp_ex_pkg::FP3_FCLASS) begin
            req_o.op = fp_ex_pkg::CLASS;
          end
        end
        fp_ex_pkg::FP7_FMVWX: begin
          if (funct3 == fp_ex_pkg::FP3_FMV) begin
            req_o.op = fp_ex_pkg::MV_WX;
          end
        end
        fp_ex_pkg::FP7_FCVTSW: begin
          // rs2 is 0 for W, 1 for WU
          if (instr_i.r.rs2[4:1] == 4'd0) begin
            req_o.op          = fp_ex_pkg::I2F;
            req_o.is_unsigned = instr_i.r.rs2[0];
          end
        end
        default: begin
          // FADD, FMUL, FDIV and the rest are not built
          req_o.op = fp_ex_pkg::NONE;
        end
      endcase
    end
  end

endmodule

// ==== verilog/fp_ex_pkg.sv ====
package fp_ex_pkg;

  // Major opcode of the OP-FP class
  localparam logic [6:0] OP_FP = 7'b1010011;

  // Single precision funct7 classes
  localparam logic [6:0] FP7_FSGNJ   = 7'b0010000;
  localparam logic [6:0] FP7_FMINMAX = 7'b0010100;
  localparam logic [6:0] FP7_FCMP    = 7'b1010000;
  localparam logic [6:0] FP7_FMVXW   = 7'b1110000;
  localparam logic [6:0] FP7_FCVTSW  = 7'b1101000;
  localparam logic [6:0] FP7_FMVWX   = 7'b1111000;

  // funct3 variants
  localparam logic [2:0] FP3_FMV    = 3'b000;
  localparam logic [2:0] FP3_FCLASS = 3'b001;
  localparam logic [2:0] FP3_FSGNJ  = 3'b000;
  localparam logic [2:0] FP3_FSGNJN = 3'b001;
  localparam logic [2:0] FP3_FMAX   = 3'b001;
  localparam logic [2:0] FP3_FLE    = 3'b000;
  localparam logic [2:0] FP3_FLT    = 3'b001;
  localparam logic [2:0] FP3_FEQ    = 3'b010;
  localparam logic [2:0] FRM_DYN    = 3'b111;

  localparam logic [31:0] CANON_NAN = 32'h7fc00000;

  // Biased exponent of 2^31, the weight of bit 31 before normalization
  localparam logic [7:0] I2F_EXP_INIT = 8'd158;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [4:0] rs3;
    logic [1:0] fmt;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r4_type_t;

  // One instruction word, two field layouts
  typedef union packed {
    r_type_t  r;
    r4_type_t r4;
  } rv_instr_u;

  typedef enum logic [2:0] {
    NONE,
    SGNJ,
    MINMAX,
    CMP,
    CLASS,
    MV_XW,
    MV_WX,
    I2F
  } fp_op_e;

  // Encoding follows the frm field
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } rm_e;

  typedef struct packed {
    fp_op_e     op;
    logic [2:0] sub;
    logic       is_unsigned;
    rm_e        rm;
  } fp_req_t;

  typedef struct packed {
    logic [31:0] frs1;
    logic [31:0] frs2;
    logic [31:0] rs1;
  } fp_operands_t;

  // Flags ordered {NV, DZ, OF, UF, NX}
  typedef struct packed {
    logic        valid;
    logic [31:0] value;
    logic [4:0]  fflags;
  } fp_res_t;

endpackage
